/* design/byte_aligner.sv */
/*
 * Stage 2. Moves both payload parts of a beat down to lane 0.
 * Lanes past each count come out as zero.
 */
`timescale 1ns/100ps
`include "msg_extract_macros.svh"

module byte_aligner (
    input  logic    clk_i,
    input  logic    reset_n_i,
    msg_lane_if.snk lane_i,
    msg_part_if.src part_o
);
    import msg_extract_pkg::*;

    logic [`MSG_BUS_BITS-1:0] cur_bytes;
    logic [`MSG_BUS_BITS-1:0] nxt_bytes;

    // Shift lanes start.. down to 0 and keep cnt of them
    function automatic logic [`MSG_BUS_BITS-1:0] take_lanes(
        input logic [`MSG_BUS_BITS-1:0] data,
        input lane_cnt_t                start,
        input lane_cnt_t                cnt
    );
        logic [`MSG_BUS_BITS-1:0] shifted;
        logic [`MSG_BUS_BITS-1:0] keep;
        shifted = data >> (32'(start) * 8);
        for (int i = 0; i < `MSG_BUS_BYTES; i++) begin
            keep[i*8 +: 8] = (i < cnt) ? 8'hFF : 8'h00;
        end
        return shifted & keep;
    endfunction

    assign cur_bytes = take_lanes(lane_i.data, lane_i.cur_start, lane_i.cur_cnt);
    assign nxt_bytes = take_lanes(lane_i.data, lane_i.nxt_start, lane_i.nxt_cnt);

    ////////////////////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            part_o.valid   <= 1'b0;
            part_o.cur_cnt <= '0;
            part_o.nxt_cnt <= '0;
            part_o.msg_end <= 1'b0;
        end else begin
            part_o.valid   <= lane_i.valid;
            part_o.cur_cnt <= lane_i.cur_cnt;
            part_o.nxt_cnt <= lane_i.nxt_cnt;
            part_o.msg_end <= lane_i.msg_end;
        end
    end

    // Byte payload
    always_ff @(posedge clk_i) begin
        part_o.cur_bytes <= cur_bytes;
        part_o.nxt_bytes <= nxt_bytes;
    end

    // Tracker never hands out more lanes than a beat has
    a_lane_sum: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        lane_i.valid |->
            (5'(lane_i.cur_cnt) + 5'(lane_i.nxt_cnt)) <= 5'(`MSG_BUS_BYTES))
        else $error("Lane counts %0d + %0d exceed the beat", lane_i.cur_cnt,
                    lane_i.nxt_cnt);

endmodule

/* design/message_extractor.sv */
/*
 * Message extractor top. Always accepts input, no back-pressure.
 * A message word appears three register stages after its last byte.
 */
`timescale 1ns/100ps
`include "msg_extract_macros.svh"

module message_extractor (
    input  logic                      clk,
    input  logic                      reset_n,

    ////////////////////////////////////////////////////////////////////////////
    // Beat stream in
    ////////////////////////////////////////////////////////////////////////////

    input  logic                      in_valid_i,
    input  logic                      in_startofpacket_i,
    input  logic                      in_endofpacket_i,
    input  logic [`MSG_BUS_BITS-1:0]  in_data_i,

    ////////////////////////////////////////////////////////////////////////////
    // Message words out
    ////////////////////////////////////////////////////////////////////////////

    output logic                      out_valid_o,
    output logic [`MSG_OUT_BITS-1:0]  out_data_o,
    output logic [`MSG_MAX_BYTES-1:0] out_bytemask_o
);

    // Lanes as received, then parts at lane 0
    msg_lane_if lane_if ();
    msg_part_if part_if ();

    // Length tracking and lane classes
    msg_len_tracker u_tracker (
        .clk_i      (clk),
        .reset_n_i  (reset_n),
        .in_valid_i (in_valid_i),
        .in_sop_i   (in_startofpacket_i),
        .in_eop_i   (in_endofpacket_i),
        .in_data_i  (in_data_i),
        .lane_o     (lane_if.src)
    );

    // Shift and mask
    byte_aligner u_aligner (
        .clk_i     (clk),
        .reset_n_i (reset_n),
        .lane_i    (lane_if.snk),
        .part_o    (part_if.src)
    );

    // Word build and emit
    msg_assembler u_assembler (
        .clk_i          (clk),
        .reset_n_i      (reset_n),
        .part_i         (part_if.snk),
        .out_valid_o    (out_valid_o),
        .out_data_o     (out_data_o),
        .out_bytemask_o (out_bytemask_o)
    );

endmodule

/* design/msg_assembler.sv */
/*
 * Stage 3. Collects payload bytes of one message at the fill pointer.
 * out_valid is a single-cycle pulse, the output has no ready.
 */
`timescale 1ns/100ps
`include "msg_extract_macros.svh"

module msg_assembler (
    input  logic                     clk_i,
    input  logic                     reset_n_i,
    msg_part_if.snk                  part_i,
    output logic                     out_valid_o,
    output logic [`MSG_OUT_BITS-1:0] out_data_o,
    output logic [`MSG_MAX_BYTES-1:0] out_bytemask_o
);
    import msg_extract_pkg::*;

    localparam int OUT_W     = `MSG_OUT_BITS;
    localparam int OUT_BYTES = `MSG_OUT_BITS / 8;

    logic [OUT_W-1:0]     buf_q;
    logic [OUT_W-1:0]     held;
    logic [OUT_W-1:0]     placed;
    logic [OUT_W-1:0]     cur_wide;
    fill_cnt_t            fill_q;
    fill_cnt_t            total;
    logic [OUT_BYTES-1:0] fill_mask;
    logic [OUT_BYTES-1:0] total_mask;

    // Low n bytes set
    function automatic logic [OUT_BYTES-1:0] byte_mask(input fill_cnt_t n);
        return ~({OUT_BYTES{1'b1}} << n);
    endfunction

    // One mask bit per byte to eight bits per byte
    function automatic logic [OUT_W-1:0] bit_mask(input logic [OUT_BYTES-1:0] m);
        logic [OUT_W-1:0] bits;
        for (int i = 0; i < OUT_BYTES; i++) begin
            bits[i*8 +: 8] = {8{m[i]}};
        end
        return bits;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Merge at fill pointer
    ////////////////////////////////////////////////////////////////////////////

    assign total      = fill_q + fill_cnt_t'(part_i.cur_cnt);
    assign fill_mask  = byte_mask(fill_q);
    assign total_mask = byte_mask(total);
    assign cur_wide   = OUT_W'(part_i.cur_bytes);

    // Stale bytes above the fill pointer are never trusted
    assign held   = buf_q & bit_mask(fill_mask);
    assign placed = held | (cur_wide << (32'(fill_q) * 8));

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            out_valid_o <= 1'b0;
            fill_q      <= '0;
        end else begin
            out_valid_o <= part_i.valid && part_i.msg_end;
            if (part_i.valid) begin
                // Next message starts with whatever followed its length field
                fill_q <= part_i.msg_end ? fill_cnt_t'(part_i.nxt_cnt) : total;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (part_i.valid) begin
            if (part_i.msg_end) begin
                out_data_o     <= placed;
                out_bytemask_o <= total_mask;
                buf_q          <= OUT_W'(part_i.nxt_bytes);
            end else begin
                buf_q <= placed;
            end
        end
    end

    // Upstream length limits keep the buffer from overflowing
    a_fill_max: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        fill_q <= `MSG_MAX_BYTES)
        else $error("Fill pointer %0d past %0d bytes", fill_q, `MSG_MAX_BYTES);

endmodule

/* design/msg_extract_macros.svh */
/*
 * Bus, field and message limits of the extractor.
 * The payload limits assume a minimum message no shorter than one beat.
 */
`ifndef MSG_EXTRACT_MACROS_SVH
`define MSG_EXTRACT_MACROS_SVH

// Input beat
`define MSG_BUS_BYTES 8
`define MSG_BUS_BITS  64

// Packet and message header fields
`define MSG_CNT_BYTES 2
`define MSG_LEN_BYTES 2

// Payload length limits in bytes
`define MSG_MIN_BYTES 8
`define MSG_MAX_BYTES 32

// Output word
`define MSG_OUT_BITS  256

// Counter widths, lanes of one beat and bytes of one message
`define MSG_LANE_W    4
`define MSG_FILL_W    6

`endif

/* design/msg_extract_pkg.sv */
/*
 * Shared types of the extractor. Lane 0 is the first byte on the wire.
 */
`include "msg_extract_macros.svh"

package msg_extract_pkg;

    // Byte count inside one beat, 0 to 8
    typedef logic [`MSG_LANE_W-1:0] lane_cnt_t;

    // Byte count inside one message, 0 to 32
    typedef logic [`MSG_FILL_W-1:0] fill_cnt_t;

    // Start-of-packet header, listed from the top lane down
    typedef struct packed {
        // Lanes 4 to 7
        logic [`MSG_BUS_BYTES-`MSG_CNT_BYTES-`MSG_LEN_BYTES-1:0][7:0] first_payload;
        // Lane 3 carries the low byte of the big-endian length
        logic [7:0] len_lo;
        // Lane 2 carries the high byte
        logic [7:0] len_hi;
        // Message count, skipped
        logic [`MSG_CNT_BYTES*8-1:0] msg_cnt;
    } sop_hdr_t;

    // Same beat seen as plain lanes or as the packet header
    typedef union packed {
        logic [`MSG_BUS_BYTES-1:0][7:0] bytes;
        sop_hdr_t                       hdr;
    } sop_beat_u;

endpackage

/* design/msg_len_tracker.sv */
/*
 * Stage 1. Expects well-formed packets with lengths of 8 to 32 bytes,
 * so at most one message ends in a beat. Non-SOP beats while idle are dropped.
 */
`timescale 1ns/100ps
`include "msg_extract_macros.svh"

module msg_len_tracker (
    input  logic                     clk_i,
    input  logic                     reset_n_i,
    input  logic                     in_valid_i,
    input  logic                     in_sop_i,
    input  logic                     in_eop_i,
    input  logic [`MSG_BUS_BITS-1:0] in_data_i,
    msg_lane_if.src                  lane_o
);
    import msg_extract_pkg::*;

    localparam lane_cnt_t BUS_B    = lane_cnt_t'(`MSG_BUS_BYTES);
    localparam lane_cnt_t LEN_B    = lane_cnt_t'(`MSG_LEN_BYTES);
    localparam lane_cnt_t SOP_SKIP = lane_cnt_t'(`MSG_CNT_BYTES + `MSG_LEN_BYTES);

    sop_beat_u                  beat;
    // Payload bytes still owed by the current message
    fill_cnt_t                  rem_q;
    fill_cnt_t                  rem_d;
    // Length bytes still due at the start of the next beat, 0 to 2
    logic [1:0]                 len_wait_q;
    logic [1:0]                 len_wait_d;
    // Top lane of the last valid beat, first half of a split length
    logic [7:0]                 strad_q;
    lane_cnt_t                  cur_start;
    lane_cnt_t                  cur_cnt;
    lane_cnt_t                  nxt_start;
    lane_cnt_t                  nxt_cnt;
    lane_cnt_t                  end_lane;
    lane_cnt_t                  new_cnt;
    logic                       msg_end;
    logic                       len_take;
    logic [`MSG_LEN_BYTES*8-1:0] len_val;

    assign beat = in_data_i;

    ////////////////////////////////////////////////////////////////////////////
    // Lane classification and next remaining count
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        cur_start  = '0;
        cur_cnt    = '0;
        nxt_start  = '0;
        nxt_cnt    = '0;
        end_lane   = '0;
        new_cnt    = '0;
        msg_end    = 1'b0;
        len_take   = 1'b0;
        len_val    = '0;
        rem_d      = rem_q;
        len_wait_d = len_wait_q;

        if (in_sop_i) begin
            // Header view, length sits in lanes 2 and 3
            len_take  = 1'b1;
            len_val   = {beat.hdr.len_hi, beat.hdr.len_lo};
            cur_start = SOP_SKIP;
            cur_cnt   = BUS_B - SOP_SKIP;
        end else if (len_wait_q == 2'd2) begin
            // Previous message ended on the beat boundary
            len_take  = 1'b1;
            len_val   = {beat.bytes[0], beat.bytes[1]};
            cur_start = LEN_B;
            cur_cnt   = BUS_B - LEN_B;
        end else if (len_wait_q == 2'd1) begin
            // Split length, high byte came in the last lane before
            len_take  = 1'b1;
            len_val   = {strad_q, beat.bytes[0]};
            cur_start = LEN_B - 1'b1;
            cur_cnt   = BUS_B - (LEN_B - 1'b1);
        end else if (rem_q > BUS_B) begin
            cur_cnt = BUS_B;
            rem_d   = rem_q - fill_cnt_t'(BUS_B);
        end else if (rem_q != '0) begin
            // Current message closes inside this beat
            msg_end  = 1'b1;
            cur_cnt  = lane_cnt_t'(rem_q);
            end_lane = lane_cnt_t'(rem_q);
            rem_d    = '0;
            if (!in_eop_i) begin
                if (end_lane <= BUS_B - LEN_B) begin
                    len_take  = 1'b1;
                    len_val   = {beat.bytes[end_lane], beat.bytes[end_lane + 1'b1]};
                    nxt_start = end_lane + LEN_B;
                    nxt_cnt   = BUS_B - LEN_B - end_lane;
                end else if (end_lane == BUS_B - 1'b1) begin
                    len_wait_d = 2'd1;
                end else begin
                    len_wait_d = 2'd2;
                end
            end
        end

        // New message, count what this beat already carries
        if (len_take) begin
            new_cnt    = msg_end ? nxt_cnt : cur_cnt;
            rem_d      = fill_cnt_t'(len_val) - fill_cnt_t'(new_cnt);
            len_wait_d = 2'd0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!reset_n_i) begin
            rem_q            <= '0;
            len_wait_q       <= 2'd0;
            lane_o.valid     <= 1'b0;
            lane_o.cur_start <= '0;
            lane_o.cur_cnt   <= '0;
            lane_o.nxt_start <= '0;
            lane_o.nxt_cnt   <= '0;
            lane_o.msg_end   <= 1'b0;
        end else begin
            lane_o.valid <= in_valid_i;
            if (in_valid_i) begin
                // End of packet drops any pending length
                rem_q            <= in_eop_i ? '0 : rem_d;
                len_wait_q       <= in_eop_i ? 2'd0 : len_wait_d;
                lane_o.cur_start <= cur_start;
                lane_o.cur_cnt   <= cur_cnt;
                lane_o.nxt_start <= nxt_start;
                lane_o.nxt_cnt   <= nxt_cnt;
                lane_o.msg_end   <= msg_end;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        lane_o.data <= in_data_i;
        if (in_valid_i) begin
            strad_q <= beat.bytes[`MSG_BUS_BYTES-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_len_range: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        in_valid_i && len_take |->
            len_val >= `MSG_MIN_BYTES && len_val <= `MSG_MAX_BYTES)
        else $error("Message length %0d outside %0d..%0d", len_val,
                    `MSG_MIN_BYTES, `MSG_MAX_BYTES);

    a_sop_valid: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        in_sop_i |-> in_valid_i)
        else $error("Start of packet without in_valid");

endmodule

/* design/msg_stage_if.sv */
/*
 * Stage-to-stage links. No ready signal, valid alone moves a beat.
 * Counts and flags mean nothing while valid is low.
 */
`timescale 1ns/100ps
`include "msg_extract_macros.svh"

////////////////////////////////////////////////////////////////////////////
// Tracker to aligner, lanes still in place
////////////////////////////////////////////////////////////////////////////

interface msg_lane_if;
    import msg_extract_pkg::*;

    logic                     valid;
    logic [`MSG_BUS_BITS-1:0] data;
    // Payload lanes of the message being filled
    lane_cnt_t                cur_start;
    lane_cnt_t                cur_cnt;
    // Payload lanes of the message that begins after it
    lane_cnt_t                nxt_start;
    lane_cnt_t                nxt_cnt;
    logic                     msg_end;

    modport src (output valid, data, cur_start, cur_cnt, nxt_start, nxt_cnt, msg_end);
    modport snk (input  valid, data, cur_start, cur_cnt, nxt_start, nxt_cnt, msg_end);
endinterface

////////////////////////////////////////////////////////////////////////////
// Aligner to assembler, both parts moved down to lane 0
////////////////////////////////////////////////////////////////////////////

interface msg_part_if;
    import msg_extract_pkg::*;

    logic                     valid;
    // Unused lanes are zero
    logic [`MSG_BUS_BITS-1:0] cur_bytes;
    lane_cnt_t                cur_cnt;
    logic [`MSG_BUS_BITS-1:0] nxt_bytes;
    lane_cnt_t                nxt_cnt;
    logic                     msg_end;

    modport src (output valid, cur_bytes, cur_cnt, nxt_bytes, nxt_cnt, msg_end);
    modport snk (input  valid, cur_bytes, cur_cnt, nxt_bytes, nxt_cnt, msg_end);
endinterface

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the message extractor testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 --top-module tb_message_extractor \
    -f sim.f -o tb_sim > "$LOG" 2>&1 \
    && ./obj_dir/tb_sim >> "$LOG" 2>&1 \
    || echo "Build or simulation ended with an error" >> "$LOG"

cat "$LOG"

grep -q "All tests passed!" "$LOG" \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

/* sim.f */
+incdir+design
+incdir+tb
design/msg_extract_pkg.sv
design/msg_stage_if.sv
design/msg_len_tracker.sv
design/byte_aligner.sv
design/msg_assembler.sv
design/message_extractor.sv
tb/tb_message_extractor.sv

/* tb/tb_msg_tasks.svh */
/*
 * Stimulus, model and directed tests, included in the testbench module.
 * Payload bytes and random choices all come from one LFSR stream.
 */
`ifndef TB_MSG_TASKS_SVH
`define TB_MSG_TASKS_SVH

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// One LFSR step per bit taken
function automatic int unsigned rand_bits(input int n);
    int unsigned val;
    val = 0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        val        = (val << 1) | 32'(lfsr_state[0]);
    end
    return val;
endfunction

// Payload length from 8 to 32
function automatic int rand_len();
    return `MSG_MIN_BYTES + int'(rand_bits(5) % (`MSG_MAX_BYTES - `MSG_MIN_BYTES + 1));
endfunction

task automatic check_value(input string what, input logic [OUT_W-1:0] expected,
                           input logic [OUT_W-1:0] actual);
    if (expected !== actual) begin
        $display("Error: %s expected 0x%0h actual 0x%0h", what, expected, actual);
        report_failure();
    end
endtask

////////////////////////////////////////////////////////////////////////////
// Packet model and beat driver
////////////////////////////////////////////////////////////////////////////

// Appends one packet made of the lengths in len_q, expected words too
task automatic build_packet();
    logic [OUT_W-1:0]          word;
    logic [`MSG_MAX_BYTES-1:0] mask;
    logic [7:0]                pay;
    int                        start;
    start = stream_q.size();
    // Message count, big-endian and ignored by the DUT
    stream_q.push_back(8'(len_q.size() >> 8));
    stream_q.push_back(8'(len_q.size()));
    foreach (len_q[m]) begin
        word = '0;
        mask = '0;
        stream_q.push_back(8'(len_q[m] >> 8));
        stream_q.push_back(8'(len_q[m]));
        // Payload byte k lands in output lane k
        for (int k = 0; k < len_q[m]; k++) begin
            pay = 8'(rand_bits(8));
            stream_q.push_back(pay);
            word[k*8 +: 8] = pay;
            mask[k]        = 1'b1;
        end
        exp_data_q.push_back(word);
        exp_mask_q.push_back(mask);
    end
    pkt_size_q.push_back(stream_q.size() - start);
    len_q.delete();
endtask

task automatic build_random_packet();
    int msgs;
    msgs = 1 + int'(rand_bits(2));
    repeat (msgs) len_q.push_back(rand_len());
    build_packet();
endtask

// Slices every queued packet into beats, lane 0 first on the wire
task automatic send_stream(input bit bubbles);
    logic [`MSG_BUS_BITS-1:0] beat;
    int                       size;
    int                       beats;
    while (pkt_size_q.size() != 0) begin
        size  = pkt_size_q.pop_front();
        beats = (size + `MSG_BUS_BYTES - 1) / `MSG_BUS_BYTES;
        for (int n = 0; n < beats; n++) begin
            // Lanes past the packet end stay zero
            beat = '0;
            for (int l = 0; l < `MSG_BUS_BYTES; l++) begin
                if (n * `MSG_BUS_BYTES + l < size) begin
                    beat[l*8 +: 8] = stream_q.pop_front();
                end
            end
            if (bubbles && rand_bits(1) == 1) begin
                @(posedge clk);
                in_valid_i         <= 1'b0;
                in_startofpacket_i <= 1'b0;
                in_endofpacket_i   <= 1'b0;
            end
            @(posedge clk);
            in_valid_i         <= 1'b1;
            in_startofpacket_i <= (n == 0);
            in_endofpacket_i   <= (n == beats - 1);
            in_data_i          <= beat;
        end
    end
endtask

// Idle the input and wait for every expected word
task automatic finish_test();
    @(posedge clk);
    in_valid_i         <= 1'b0;
    in_startofpacket_i <= 1'b0;
    in_endofpacket_i   <= 1'b0;
    while (exp_data_q.size() != 0) begin
        @(posedge clk);
    end
    // Let the pipeline drain so a surplus word still reaches the monitor
    repeat (QUIET_CYCLES) @(posedge clk);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_single_message();
    cur_test = "single message";
    len_q.push_back(8);
    build_packet();
    send_stream(1'b0);
    finish_test();
endtask

task automatic test_split_fields();
    cur_test = "split length fields";
    len_q.push_back(13);
    len_q.push_back(9);
    len_q.push_back(32);
    build_packet();
    // Second length straddles a beat edge, third starts a fresh beat
    len_q.push_back(11);
    len_q.push_back(15);
    len_q.push_back(20);
    build_packet();
    send_stream(1'b0);
    finish_test();
endtask

task automatic test_random_packets();
    cur_test   = "random packets";
    saved_lfsr = lfsr_state;
    repeat (RAND_PKTS) build_random_packet();
    send_stream(1'b0);
    finish_test();
endtask

// Same packets again, rebuilt from the saved LFSR state
task automatic test_random_bubbles();
    cur_test   = "random packets with bubbles";
    lfsr_state = saved_lfsr;
    repeat (RAND_PKTS) build_random_packet();
    send_stream(1'b1);
    finish_test();
endtask

task automatic test_reset_mid_packet();
    cur_test = "reset mid packet";
    // Header of a 32-byte message that never completes
    @(posedge clk);
    in_valid_i         <= 1'b1;
    in_startofpacket_i <= 1'b1;
    in_endofpacket_i   <= 1'b0;
    in_data_i          <= {rand_bits(32), 8'h20, 8'h00, 8'h01, 8'h00};
    @(posedge clk);
    in_startofpacket_i <= 1'b0;
    in_data_i          <= {rand_bits(32), rand_bits(32)};
    @(posedge clk);
    in_valid_i <= 1'b0;
    reset_n    <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    repeat (QUIET_CYCLES) begin
        @(posedge clk);
        check_value({cur_test, " out_valid"}, '0, OUT_W'(out_valid_o));
    end
    len_q.push_back(rand_len());
    build_packet();
    send_stream(1'b0);
    finish_test();
endtask

`endif

/* tb/tb_message_extractor.sv */
/*
 * Testbench for the message extractor. Stops at the first failing check.
 * Expected words come from a byte-list model of each packet.
 */
`timescale 1ns/100ps
`include "msg_extract_macros.svh"

module tb_message_extractor;

    localparam int OUT_W          = `MSG_OUT_BITS;
    localparam int RESET_CYCLES   = 10;
    localparam int QUIET_CYCLES   = 5;
    localparam int NUM_TESTS      = 5;
    localparam int RAND_PKTS      = 10;
    localparam int MAX_MSGS       = 4;
    // Longest random packet in beats
    localparam int PKT_MAX_BEATS  = (`MSG_CNT_BYTES + MAX_MSGS * (`MSG_LEN_BYTES + `MSG_MAX_BYTES)
                                     + `MSG_BUS_BYTES - 1) / `MSG_BUS_BYTES;
    // Fixed packets, random packets twice plus one bubble per beat, reset test
    localparam int STIM_CYCLES    = 2 + 15 + 3 * RAND_PKTS * PKT_MAX_BEATS
                                    + 3 + RESET_CYCLES + QUIET_CYCLES + PKT_MAX_BEATS;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + 20 * NUM_TESTS;

    logic                      clk;
    logic                      reset_n;
    logic                      in_valid_i;
    logic                      in_startofpacket_i;
    logic                      in_endofpacket_i;
    logic [`MSG_BUS_BITS-1:0]  in_data_i;
    logic                      out_valid_o;
    logic [`MSG_OUT_BITS-1:0]  out_data_o;
    logic [`MSG_MAX_BYTES-1:0] out_bytemask_o;

    // Model state shared by the tasks and the monitor
    logic [7:0]                stream_q[$];
    int                        pkt_size_q[$];
    int                        len_q[$];
    logic [`MSG_OUT_BITS-1:0]  exp_data_q[$];
    logic [`MSG_MAX_BYTES-1:0] exp_mask_q[$];
    logic [31:0]               lfsr_state = 32'ha9a1;
    logic [31:0]               saved_lfsr;
    int                        cycle_cnt  = 0;
    string                     cur_test   = "startup";

    message_extractor UUT (
        .clk                (clk),
        .reset_n            (reset_n),
        .in_valid_i         (in_valid_i),
        .in_startofpacket_i (in_startofpacket_i),
        .in_endofpacket_i   (in_endofpacket_i),
        .in_data_i          (in_data_i),
        .out_valid_o        (out_valid_o),
        .out_data_o         (out_data_o),
        .out_bytemask_o     (out_bytemask_o)
    );

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    `include "tb_msg_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor and run limit
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (out_valid_o) begin
            if (exp_data_q.size() == 0) begin
                $display("Unexpected out_valid with no message pending in test %s", cur_test);
                report_failure();
            end else begin
                check_value({cur_test, " data"}, exp_data_q.pop_front(), out_data_o);
                check_value({cur_test, " mask"}, OUT_W'(exp_mask_q.pop_front()),
                            OUT_W'(out_bytemask_o));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in test %s, messages still missing",
                     cycle_cnt, cur_test);
            report_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset_n            = 1'b0;
        in_valid_i         = 1'b0;
        in_startofpacket_i = 1'b0;
        in_endofpacket_i   = 1'b0;
        in_data_i          = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        test_single_message();
        test_split_fields();
        test_random_packets();
        test_random_bubbles();
        test_reset_mid_packet();

        if (exp_data_q.size() != 0) begin
            $display("%0d expected messages never came out", exp_data_q.size());
            report_failure();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule
